// File: common/video_pkg.sv
`default_nettype none

package video_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // plain widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef logic [3:0] color_t;   // vdp palette index
   typedef logic [8:0] col_t;     // pixel column, up to 512
   typedef logic [9:0] len_t;     // input ticks within a line

   typedef struct packed {
      logic [3:0] red;
      logic [3:0] green;
      logic [3:0] blue;
   } rgb_t;

   typedef struct packed {
      logic   hsync;
      logic   active;
      color_t color;
   } vdp_pixel_t;

   typedef struct packed {
      logic   hsync;
      logic   active;
      logic   stb;      // one clock per output pixel
      color_t color;
   } vga_pixel_t;

   // description of one finished input line
   typedef struct packed {
      logic bank;
      len_t line_len;
      len_t sync_len;
      len_t act_start;
      col_t act_count;
   } line_info_t;

   // tms9918 colours, top nibble of each 8-bit channel
   localparam rgb_t PALETTE [16] = '{
      12'h000, 12'h000, 12'h2C4, 12'h5D7,
      12'h55E, 12'h77F, 12'hD54, 12'h4EF,
      12'hF55, 12'hF77, 12'hDC5, 12'hEC8,
      12'h2B3, 12'hC5B, 12'hCCC, 12'hFFF
   };

endpackage

`default_nettype wire

// File: source/clock_enables.sv
`timescale 1ns/100ps
`default_nettype none

module clock_enables (
   input  logic clk_i,
   input  logic reset_i,
   output logic vga_en_o,
   output logic vdp_en_o
);

   logic [1:0] cnt;

   // both enables decoded from one count, so vdp_en always lands on a vga_en
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt      <= 2'd0;
         vga_en_o <= 1'b0;
         vdp_en_o <= 1'b0;
      end else begin
         cnt      <= cnt + 2'd1;
         vga_en_o <= cnt[0];          // every 2nd clock
         vdp_en_o <= (cnt == 2'd3);   // every 4th clock
      end
   end

endmodule

`default_nettype wire

// File: scandoubler/line_writer.sv
`timescale 1ns/100ps
`default_nettype none

module line_writer #(
   parameter int LINE_PIXELS = 320
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  en_i,
   input  video_pkg::vdp_pixel_t pixel_i,
   output logic                  wr_req_o,
   input  logic                  wr_gnt_i,
   output logic                  wr_bank_o,
   output video_pkg::col_t       wr_col_o,
   output video_pkg::color_t     wr_data_o,
   output logic                  line_start_o,
   output video_pkg::line_info_t line_info_o
);
   import video_pkg::*;

   logic prev_hsync;
   logic bank;
   logic started;      // a full line has begun since reset
   logic seen_act;
   len_t tick;
   len_t sync_cnt;
   len_t act_pos;
   col_t act_cnt;

   logic line_edge;
   logic take;
   len_t tick_base;
   len_t sync_base;
   len_t pos_base;
   col_t cnt_base;
   logic seen_base;

   // counters restart from zero on the sample that opens a line
   always_comb begin
      line_edge = pixel_i.hsync && !prev_hsync;
      tick_base = line_edge ? '0 : tick;
      sync_base = line_edge ? '0 : sync_cnt;
      pos_base  = line_edge ? '0 : act_pos;
      cnt_base  = line_edge ? '0 : act_cnt;
      seen_base = line_edge ? 1'b0 : seen_act;
      take      = pixel_i.active && (len_t'(cnt_base) < len_t'(LINE_PIXELS));
   end

   assign wr_bank_o = bank;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         prev_hsync   <= 1'b0;
         bank         <= 1'b0;
         started      <= 1'b0;
         seen_act     <= 1'b0;
         tick         <= '0;
         sync_cnt     <= '0;
         act_pos      <= '0;
         act_cnt      <= '0;
         wr_req_o     <= 1'b0;
         line_start_o <= 1'b0;
         line_info_o  <= '0;
      end else begin
         line_start_o <= 1'b0;
         if (wr_gnt_i)
            wr_req_o <= 1'b0;
         if (en_i) begin
            prev_hsync <= pixel_i.hsync;
            tick       <= tick_base + len_t'(1);
            sync_cnt   <= pixel_i.hsync ? sync_base + len_t'(1) : sync_base;
            act_pos    <= (pixel_i.active && !seen_base) ? tick_base : pos_base;
            seen_act   <= seen_base || pixel_i.active;
            act_cnt    <= take ? cnt_base + col_t'(1) : cnt_base;
            if (take)
               wr_req_o <= 1'b1;
            if (line_edge) begin
               bank         <= ~bank;
               started      <= 1'b1;
               line_start_o <= started;   // first edge has no finished line yet
               line_info_o  <= '{bank: bank, line_len: tick, sync_len: sync_cnt,
                                 act_start: act_pos, act_count: act_cnt};
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (en_i && take) begin
         wr_col_o  <= cnt_base;
         wr_data_o <= pixel_i.color;
      end
   end

endmodule

`default_nettype wire

// File: scandoubler/line_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module line_arbiter (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              wr_req_i,
   input  logic              wr_bank_i,
   input  video_pkg::col_t   wr_col_i,
   input  video_pkg::color_t wr_data_i,
   output logic              wr_gnt_o,
   input  logic              rd_req_i,
   input  logic              rd_bank_i,
   input  video_pkg::col_t   rd_col_i,
   output logic              rd_gnt_o,
   output logic              ram_en_o,
   output logic              ram_we_o,
   output logic              ram_bank_o,
   output video_pkg::col_t   ram_col_o,
   output video_pkg::color_t ram_wdata_o
);

   // writer always goes first
   assign wr_gnt_o = wr_req_i;
   assign rd_gnt_o = rd_req_i && !wr_req_i;

   // steer the winner onto the single port
   assign ram_en_o    = wr_gnt_o || rd_gnt_o;
   assign ram_we_o    = wr_gnt_o;
   assign ram_bank_o  = wr_gnt_o ? wr_bank_i : rd_bank_i;
   assign ram_col_o   = wr_gnt_o ? wr_col_i : rd_col_i;
   assign ram_wdata_o = wr_data_i;

endmodule

`default_nettype wire

// File: scandoubler/line_ram.sv
`timescale 1ns/100ps
`default_nettype none

module line_ram #(
   parameter int LINE_PIXELS = 320
) (
   input  logic              clk_i,
   input  logic              en_i,
   input  logic              we_i,
   input  logic              bank_i,
   input  video_pkg::col_t   col_i,
   input  video_pkg::color_t wdata_i,
   output video_pkg::color_t rdata_o
);
   import video_pkg::*;

   color_t mem [2][LINE_PIXELS];   // one bank filling, one replaying

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         if (we_i)
            mem[bank_i][col_i] <= wdata_i;
         else
            rdata_o <= mem[bank_i][col_i];   // valid the clock after the grant
      end
   end

endmodule

`default_nettype wire

// File: scandoubler/line_reader.sv
`timescale 1ns/100ps
`default_nettype none

module line_reader #(
   parameter int LINE_PIXELS = 320
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  en_i,
   input  logic                  line_start_i,
   input  video_pkg::line_info_t line_info_i,
   output logic                  rd_req_o,
   output logic                  rd_bank_o,
   output video_pkg::col_t       rd_col_o,
   input  logic                  rd_gnt_i,
   input  video_pkg::color_t     rd_data_i,
   output video_pkg::vga_pixel_t pixel_o
);
   import video_pkg::*;

   typedef enum logic [1:0] {s_idle, s_first_pass, s_second_pass} state_t;

   state_t     state;
   line_info_t info;
   len_t       tick;         // output tick handled at the next enable
   logic       stg_hsync;
   logic       stg_active;
   logic       rd_valid;
   color_t     data_q;

   logic       replaying;
   logic       last_tick;
   logic       final_tick;
   len_t       tick_nxt;

   function automatic logic in_active(line_info_t li, len_t x);
      len_t k;
      k = x - li.act_start;
      return (x >= li.act_start) && (k < len_t'(li.act_count))
             && (k < len_t'(LINE_PIXELS));
   endfunction

   function automatic col_t col_of(line_info_t li, len_t x);
      return col_t'(x - li.act_start);
   endfunction

   assign replaying  = (state != s_idle);
   assign last_tick  = (tick == info.line_len - len_t'(1));
   assign final_tick = last_tick && (state == s_second_pass);
   assign tick_nxt   = last_tick ? '0 : tick + len_t'(1);
   assign rd_bank_o  = info.bank;   // the bank the writer just left

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tick counter, read requests, output stage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state      <= s_idle;
         info       <= '0;
         tick       <= '0;
         stg_hsync  <= 1'b0;
         stg_active <= 1'b0;
         rd_req_o   <= 1'b0;
         rd_valid   <= 1'b0;
         pixel_o    <= '0;
      end else begin
         rd_valid    <= rd_gnt_i;
         pixel_o.stb <= 1'b0;
         if (rd_gnt_i)
            rd_req_o <= 1'b0;

         if (line_start_i) begin
            // restart on a new line, even mid replay
            state      <= s_first_pass;
            info       <= line_info_i;
            tick       <= '0;
            stg_hsync  <= 1'b0;
            stg_active <= 1'b0;
            rd_req_o   <= in_active(line_info_i, '0);
         end else if (en_i) begin
            pixel_o.hsync  <= stg_hsync;
            pixel_o.active <= stg_active;
            pixel_o.stb    <= stg_active;
            pixel_o.color  <= stg_active ? data_q : '0;
            stg_hsync      <= replaying && (tick < info.sync_len);
            stg_active     <= replaying && in_active(info, tick);
            if (replaying) begin
               tick <= tick_nxt;
               if (last_tick)
                  state <= (state == s_first_pass) ? s_second_pass : s_idle;
               if (!final_tick)
                  rd_req_o <= in_active(info, tick_nxt);   // one tick ahead
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (line_start_i)
         rd_col_o <= col_of(line_info_i, '0);
      else if (en_i && replaying)
         rd_col_o <= col_of(info, tick_nxt);
      if (rd_valid)
         data_q <= rd_data_i;   // held until the pixel leaves
   end

endmodule

`default_nettype wire

// File: source/color_to_rgb.sv
`timescale 1ns/100ps
`default_nettype none

module color_to_rgb (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  video_pkg::vga_pixel_t pixel_i,
   input  video_pkg::color_t     overlay_i,
   output video_pkg::rgb_t       rgb_o,
   output logic                  hsync_o,
   output logic                  active_o,
   output logic                  stb_o
);
   import video_pkg::*;

   color_t sel;
   rgb_t   rgb_d;

   always_comb begin
      sel   = (overlay_i != '0) ? overlay_i : pixel_i.color;   // overlay wins
      rgb_d = pixel_i.active ? PALETTE[sel] : '0;              // black outside active
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rgb_o    <= '0;
         hsync_o  <= 1'b0;
         active_o <= 1'b0;
         stb_o    <= 1'b0;
      end else begin
         rgb_o    <= rgb_d;
         hsync_o  <= pixel_i.hsync;
         active_o <= pixel_i.active;
         stb_o    <= pixel_i.stb;
      end
   end

endmodule

`default_nettype wire

// File: source/video_out_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_out_top #(
   parameter int LINE_PIXELS = 320
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  video_pkg::vdp_pixel_t vdp_pixel_i,
   input  video_pkg::color_t     overlay_i,
   output video_pkg::rgb_t       rgb_o,
   output logic                  hsync_o,
   output logic                  active_o,
   output logic                  pixel_stb_o
);
   import video_pkg::*;

   logic       vga_en;
   logic       vdp_en;

   logic       wr_req, wr_gnt, wr_bank;
   col_t       wr_col;
   color_t     wr_data;
   logic       line_start;
   line_info_t line_info;

   logic       rd_req, rd_gnt, rd_bank;
   col_t       rd_col;
   color_t     rd_data;

   logic       ram_en, ram_we, ram_bank;
   col_t       ram_col;
   color_t     ram_wdata;

   vga_pixel_t vga_pixel;

   clock_enables enables(.clk_i(clk_i), .reset_i(reset_i),
                         .vga_en_o(vga_en), .vdp_en_o(vdp_en));

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // scan doubler
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   line_writer #(.LINE_PIXELS(LINE_PIXELS))
     writer(.clk_i(clk_i), .reset_i(reset_i), .en_i(vdp_en), .pixel_i(vdp_pixel_i),
            .wr_req_o(wr_req), .wr_gnt_i(wr_gnt), .wr_bank_o(wr_bank),
            .wr_col_o(wr_col), .wr_data_o(wr_data),
            .line_start_o(line_start), .line_info_o(line_info));

   line_arbiter
     arbiter(.clk_i(clk_i), .reset_i(reset_i),
             .wr_req_i(wr_req), .wr_bank_i(wr_bank), .wr_col_i(wr_col),
             .wr_data_i(wr_data), .wr_gnt_o(wr_gnt),
             .rd_req_i(rd_req), .rd_bank_i(rd_bank), .rd_col_i(rd_col),
             .rd_gnt_o(rd_gnt),
             .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_bank_o(ram_bank),
             .ram_col_o(ram_col), .ram_wdata_o(ram_wdata));

   line_ram #(.LINE_PIXELS(LINE_PIXELS))
     ram(.clk_i(clk_i), .en_i(ram_en), .we_i(ram_we), .bank_i(ram_bank),
         .col_i(ram_col), .wdata_i(ram_wdata), .rdata_o(rd_data));

   line_reader #(.LINE_PIXELS(LINE_PIXELS))
     reader(.clk_i(clk_i), .reset_i(reset_i), .en_i(vga_en),
            .line_start_i(line_start), .line_info_i(line_info),
            .rd_req_o(rd_req), .rd_bank_o(rd_bank), .rd_col_o(rd_col),
            .rd_gnt_i(rd_gnt), .rd_data_i(rd_data), .pixel_o(vga_pixel));

   color_to_rgb
     color_stage(.clk_i(clk_i), .reset_i(reset_i),
                 .pixel_i(vga_pixel), .overlay_i(overlay_i), .rgb_o(rgb_o),
                 .hsync_o(hsync_o), .active_o(active_o), .stb_o(pixel_stb_o));

endmodule

`default_nettype wire

// File: bench/video_checker.sv
`timescale 1ns/100ps
`default_nettype none

module video_checker #(
   parameter int LINE_PIXELS = 320
) (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  vdp_en_i,
   input  video_pkg::vdp_pixel_t vdp_pixel_i,
   input  video_pkg::color_t     overlay_i,
   input  video_pkg::rgb_t       rgb_i,
   input  logic                  hsync_i,
   input  logic                  active_i,
   input  logic                  stb_i,
   input  logic                  done_i,
   output int                    errors_o,
   output int                    lines_done_o
);
   import video_pkg::*;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input line being captured
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   color_t cur_colors [$];
   int     cur_len;
   int     cur_sync;
   int     in_edges;
   logic   in_hs_prev;

   // completed lines waiting to be replayed
   rgb_t   exp_rgb [$];
   int     exp_cnt [$];
   int     exp_sync [$];
   int     exp_len [$];

   logic   out_hs_prev;
   logic   out_rise;
   logic   line_open;
   int     pass;        // 0 first copy, 1 second copy
   int     cyc;
   int     hs_cnt;
   int     act_clks;
   int     stb_cnt;
   int     line_errs;

   initial begin
      errors_o     = 0;
      lines_done_o = 0;
      in_edges     = 0;
      in_hs_prev   = 1'b0;
      out_hs_prev  = 1'b0;
      line_open    = 1'b0;
      pass         = 0;
      line_errs    = 0;
      cur_len      = 0;
      cur_sync     = 0;
   end

   function automatic rgb_t expected_rgb(color_t ov, color_t c);
      return (ov != 4'd0) ? PALETTE[ov] : PALETTE[c];   // overlay wins when set
   endfunction

   task automatic report_fail(input string msg);
      errors_o++;
      line_errs++;
      $display("[FAIL] %0t: %s", $time, msg);
   endtask

   task automatic check_quiet();
      if (hsync_i !== 1'b0 || active_i !== 1'b0 || stb_i !== 1'b0 || rgb_i !== '0)
         report_fail($sformatf("outputs not idle before first full line, rgb %h", rgb_i));
   endtask

   // same samples the DUT takes on the next rising edge
   task automatic capture_input();
      if (vdp_pixel_i.hsync && !in_hs_prev) begin
         in_edges++;
         if (in_edges > 1) begin
            // replay runs while the next line comes in, so its overlay applies
            foreach (cur_colors[i])
               exp_rgb.push_back(expected_rgb(overlay_i, cur_colors[i]));
            exp_cnt.push_back(cur_colors.size());
            exp_sync.push_back(cur_sync);
            exp_len.push_back(cur_len);
         end
         cur_colors.delete();
         cur_len  = 0;
         cur_sync = 0;
      end
      cur_len++;
      if (vdp_pixel_i.hsync)
         cur_sync++;
      if (vdp_pixel_i.active && cur_colors.size() < LINE_PIXELS)
         cur_colors.push_back(vdp_pixel_i.color);
      in_hs_prev = vdp_pixel_i.hsync;
   endtask

   task automatic close_line();
      if (hs_cnt != 2 * exp_sync[0])
         report_fail($sformatf("hsync high %0d clocks, expected %0d", hs_cnt,
                               2 * exp_sync[0]));
      if (act_clks != 2 * exp_cnt[0])
         report_fail($sformatf("active high %0d clocks, expected %0d", act_clks,
                               2 * exp_cnt[0]));
      if (stb_cnt != exp_cnt[0])
         report_fail($sformatf("%0d pixels in output line, expected %0d", stb_cnt,
                               exp_cnt[0]));
      if (pass == 0) begin
         if (!(out_rise && cyc == 2 * exp_len[0]))
            report_fail($sformatf("first output line spans %0d clocks, expected %0d", cyc,
                                  2 * exp_len[0]));
         pass = 1;
      end else begin
         if (line_errs == 0)
            $display("line %0d: ok, %0d pixels shown twice", lines_done_o, exp_cnt[0]);
         else
            $display("line %0d: %0d errors", lines_done_o, line_errs);
         repeat (exp_cnt[0])
            void'(exp_rgb.pop_front());
         void'(exp_cnt.pop_front());
         void'(exp_sync.pop_front());
         void'(exp_len.pop_front());
         lines_done_o++;
         line_errs = 0;
         pass      = 0;
      end
      line_open = 1'b0;
   endtask

   task automatic track_output();
      out_rise    = hsync_i && !out_hs_prev;
      out_hs_prev = hsync_i;
      // an output line ends at the next hsync or after its full length
      if (line_open && (out_rise || cyc == 2 * exp_len[0]))
         close_line();
      if (out_rise) begin
         if (exp_cnt.size() == 0) begin
            report_fail("output line with no completed input line");
         end else begin
            line_open = 1'b1;
            cyc       = 0;
            hs_cnt    = 0;
            act_clks  = 0;
            stb_cnt   = 0;
         end
      end
      if (line_open) begin
         if (hsync_i)
            hs_cnt++;
         if (active_i)
            act_clks++;
         if (stb_i) begin
            if (stb_cnt >= exp_cnt[0])
               report_fail($sformatf("extra pixel %0d in output line", stb_cnt));
            else if (rgb_i !== exp_rgb[stb_cnt])
               report_fail($sformatf("pixel %0d rgb %h, expected %h", stb_cnt, rgb_i,
                                     exp_rgb[stb_cnt]));
            stb_cnt++;
         end
         cyc++;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // sample away from the active edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always @(negedge clk_i) begin
      if (reset_i) begin
         in_hs_prev  = 1'b0;
         out_hs_prev = 1'b0;
         line_open   = 1'b0;
         pass        = 0;
         check_quiet();
      end else begin
         if (vdp_en_i)
            capture_input();
         if (in_edges < 2)
            check_quiet();
         if (active_i == 1'b0 && rgb_i != '0)
            report_fail($sformatf("rgb %h outside active video", rgb_i));
         track_output();
      end
   end

   always @(posedge done_i)
      $display("lines checked %0d, errors %0d", lines_done_o, errors_o);

endmodule

`default_nettype wire

// File: bench/video_tb.sv
`timescale 1ns/100ps
`default_nettype none

module video_tb;
   import video_pkg::*;

   localparam int LINE_PIXELS    = 320;
   localparam int NUM_LINES      = 40;
   localparam int LONG_LINE      = NUM_LINES - 2;   // overflow case, still replayed
   localparam int TIMEOUT_CLOCKS = NUM_LINES * 200 * 4 + 8000;

   logic       clk;
   logic       reset;
   vdp_pixel_t vdp_pixel;
   color_t     overlay;
   rgb_t       rgb;
   logic       hsync;
   logic       active;
   logic       pixel_stb;
   logic       done;
   int         errors;
   int         lines_done;
   int         seed;

   video_out_top #(.LINE_PIXELS(LINE_PIXELS))
     UUT(.clk_i(clk), .reset_i(reset), .vdp_pixel_i(vdp_pixel), .overlay_i(overlay),
         .rgb_o(rgb), .hsync_o(hsync), .active_o(active), .pixel_stb_o(pixel_stb));

   video_checker #(.LINE_PIXELS(LINE_PIXELS))
     line_check(.clk_i(clk), .reset_i(reset), .vdp_en_i(UUT.vdp_en),
                .vdp_pixel_i(vdp_pixel), .overlay_i(overlay), .rgb_i(rgb),
                .hsync_i(hsync), .active_i(active), .stb_i(pixel_stb), .done_i(done),
                .errors_o(errors), .lines_done_o(lines_done));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic int draw(input int span);
      return $unsigned($random(seed)) % span;
   endfunction

   // returns just after the DUT took the current input
   task automatic wait_sampled();
      @(negedge clk);
      while (!UUT.vdp_en)
         @(negedge clk);
      @(posedge clk);
      #10;
   endtask

   task automatic send_line(input int len, input int sync, input int act, input int cnt,
                            input color_t ov);
      vdp_pixel_t p;
      for (int t = 0; t < len; t++) begin
         p.hsync   = (t < sync);
         p.active  = (t >= act) && (t < act + cnt);
         p.color   = p.active ? color_t'(draw(16)) : 4'd0;
         vdp_pixel = p;
         overlay   = ov;
         wait_sampled();
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      int     len;
      int     sync;
      int     act;
      int     cnt;
      int     prev_len;
      int     prev_end;
      int     burst_left;
      color_t burst_col;
      color_t ov;

      seed       = 76;
      vdp_pixel  = '0;
      overlay    = '0;
      reset      = 1'b1;
      done       = 1'b0;
      prev_len   = 0;
      prev_end   = 0;
      burst_left = 0;
      burst_col  = '0;
      repeat (8) @(posedge clk);
      #10 reset = 1'b0;

      for (int i = 0; i < NUM_LINES; i++) begin
         if (i == LONG_LINE) begin
            len  = 400;
            sync = 16;
            act  = 24;
            cnt  = 360;   // more than the line memory holds
         end else begin
            sync = 8 + draw(13);
            act  = sync + 1 + draw(16);
            cnt  = draw(91);
            len  = 120 + draw(81);
            if (len < act + cnt + 2)
               len = act + cnt + 2;
            // second copy of the previous line must finish inside this one
            if (i > 0 && len < (prev_len + prev_end) / 2 + 4)
               len = (prev_len + prev_end) / 2 + 4;
         end
         if (burst_left == 0) begin
            if (draw(6) == 0) begin
               burst_col  = color_t'(1 + draw(15));
               burst_left = 1 + draw(3);
            end else begin
               burst_col = '0;
            end
         end
         ov = (burst_left > 0) ? burst_col : 4'd0;
         if (burst_left > 0)
            burst_left--;
         send_line(len, sync, act, cnt, ov);
         prev_len = len;
         prev_end = act + cnt;
      end

      // the last line never gets a closing edge, so it is not replayed
      wait (lines_done == NUM_LINES - 1);
      @(posedge clk);
      #10 done = 1'b1;
      #1;
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial begin
      #(TIMEOUT_CLOCKS * 100);
      $display("run timed out after %0d clocks, output lines stopped arriving",
               TIMEOUT_CLOCKS);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
common/video_pkg.sv
source/clock_enables.sv
scandoubler/line_writer.sv
scandoubler/line_arbiter.sv
scandoubler/line_ram.sv
scandoubler/line_reader.sv
source/color_to_rgb.sv
source/video_out_top.sv
bench/video_checker.sv
bench/video_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the scan doubler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module video_tb -f project.f -o video_sim

./obj_dir/video_sim | tee sim.log

# pass only if the testbench printed its pass line
grep -q "^Finished with no errors$" sim.log
echo "simulation passed"
